// ==== Makefile ====
# Verilator build for the DOC sound engine testbench
VERILATOR ?= verilator
TOP       ?= tb_doc
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "STATUS: PASS" $(LOG) || (echo "Simulation did not pass"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== rtl/doc_config.svh ====
//------------------------------------------------
// DOC sound engine constants
// Widths, oscillator count and host register map
//------------------------------------------------
`ifndef DOC_CONFIG_SVH
`define DOC_CONFIG_SVH

`define DOC_NUM_OSC      32       // Oscillator slots
`define DOC_OSC_IDX_W    5        // Oscillator index width
`define DOC_REG_W        8        // Host data byte
`define DOC_ACC_W        24       // Phase accumulator
`define DOC_WAVE_ADDR_W  16       // Wave memory address
`define DOC_SAMPLE_W     16       // Scaled sample and mono output
`define DOC_MIX_W        24       // Frame sum, headroom for 32 voices

// Register regions, 32 bytes each
`define DOC_BASE_FL      8'h00    // Frequency low
`define DOC_BASE_FH      8'h20    // Frequency high
`define DOC_BASE_VOL     8'h40    // Volume
`define DOC_BASE_WDS     8'h60    // Last wave sample
`define DOC_BASE_WTP     8'h80    // Wavetable pointer
`define DOC_BASE_CTL     8'hA0    // Control
`define DOC_BASE_RTS     8'hC0    // Resolution / table size
`define DOC_ADDR_OSC_EN  8'hE1    // Oscillator enable
`define DOC_SHIFT_BASE   9        // Address shift before res/wts

`endif

// ==== rtl/doc_mixer.sv ====
`timescale 1ns/1ns
//------------------------------------------------
// DOC mono mixer
// Scales samples by volume, sums one frame and
// publishes the saturated 16-bit result
//------------------------------------------------
`include "doc_config.svh"

module doc_mixer
    import doc_pkg::*;
(
    input  logic                            clk_i,
    input  logic                            reset_n_i,
    input  osc_sample_t                     sample_i,
    input  logic                            frame_done_i,
    output logic signed [`DOC_SAMPLE_W-1:0] mono_o,
    output logic                            mono_valid_o
);

    localparam logic signed [`DOC_MIX_W-1:0] SAT_MAX = 32767;
    localparam logic signed [`DOC_MIX_W-1:0] SAT_MIN = -32768;

    logic signed [`DOC_REG_W:0]      vol_w;      // Volume as non-negative signed
    logic signed [16:0]              prod_w;
    logic signed [`DOC_MIX_W-1:0]    contrib_w;
    logic signed [`DOC_MIX_W-1:0]    next_sum_w;
    logic signed [`DOC_MIX_W-1:0]    sum_r;
    logic signed [`DOC_SAMPLE_W-1:0] sat_w;

    always_comb begin
        vol_w  = $signed({1'b0, sample_i.vol});
        prod_w = 17'(sample_i.wave) * 17'(vol_w);
        if (sample_i.valid) contrib_w = `DOC_MIX_W'(prod_w);
        else contrib_w = '0;
        next_sum_w = sum_r + contrib_w;
        // Clamp to 16-bit range
        if (next_sum_w > SAT_MAX) sat_w = 16'sh7FFF;
        else if (next_sum_w < SAT_MIN) sat_w = 16'sh8000;
        else sat_w = next_sum_w[`DOC_SAMPLE_W-1:0];
    end

    always_ff @(posedge clk_i) begin
        if (!reset_n_i) begin
            sum_r        <= '0;
            mono_o       <= '0;
            mono_valid_o <= 1'b0;
        end else begin
            mono_valid_o <= frame_done_i;
            if (frame_done_i) begin
                mono_o <= sat_w;
                sum_r  <= '0;               // Next frame starts empty
            end else begin
                sum_r <= next_sum_w;
            end
        end
    end

endmodule

// ==== rtl/doc_osc_engine.sv ====
`timescale 1ns/1ns
//------------------------------------------------
// DOC oscillator engine
// Visits oscillators 0..osc_max once per frame,
// forms the wave address, fetches one byte over
// a four-phase handshake, steps the accumulator
// and issues write-back and sample
//------------------------------------------------
`include "doc_config.svh"

module doc_osc_engine
    import doc_pkg::*;
(
    input  logic                        clk_i,
    input  logic                        reset_n_i,
    output logic [`DOC_OSC_IDX_W-1:0]   osc_idx_o,
    input  osc_regs_t                   osc_regs_i,
    input  logic [`DOC_OSC_IDX_W-1:0]   osc_max_i,
    output osc_wb_t                     wb_o,
    output logic                        wave_req_o,
    output logic [`DOC_WAVE_ADDR_W-1:0] wave_addr_o,
    input  logic                        wave_ack_i,
    input  logic [`DOC_REG_W-1:0]       wave_data_i,
    output osc_sample_t                 sample_o,
    output logic                        frame_done_o
);

    localparam logic [`DOC_ACC_W:0] ACC_ONE = 1;

    osc_state_e                state_r;
    logic [`DOC_OSC_IDX_W-1:0] idx_r;                  // Oscillator in flight
    logic [`DOC_ACC_W-1:0]     acc_r [`DOC_NUM_OSC];   // Phase accumulators
    osc_regs_t                 regs_q;                 // Snapshot held for ACC
    logic [`DOC_REG_W-1:0]     data_q;                 // Fetched byte

    logic [2:0]                  wts_w;
    logic [2:0]                  res_w;
    logic [4:0]                  shift_w;
    logic [`DOC_REG_W-1:0]       ptr_mask_w;
    logic [`DOC_WAVE_ADDR_W-1:0] addr_w;
    logic [`DOC_ACC_W:0]         sum_w;        // One carry bit above the accumulator
    logic [`DOC_ACC_W:0]         wrap_mask_w;
    logic [4:0]                  high_bit_w;
    logic                        overflow_w;
    osc_mode_e                   mode_w;

    assign osc_idx_o = idx_r;      // Stable for the whole visit

    // Address from the live snapshot during ADDR
    always_comb begin
        wts_w      = osc_regs_i.rts[5:3];
        res_w      = osc_regs_i.rts[2:0];
        shift_w    = 5'(`DOC_SHIFT_BASE) + 5'(res_w) - 5'(wts_w);
        ptr_mask_w = 8'hFF << wts_w;                   // Larger tables drop low pointer bits
        addr_w     = `DOC_WAVE_ADDR_W'(acc_r[idx_r] >> shift_w)
                   | {osc_regs_i.wtp & ptr_mask_w, 8'h00};
    end

    // Accumulator step from the held snapshot during ACC
    always_comb begin
        high_bit_w  = 5'd17 + 5'(regs_q.rts[2:0]);
        sum_w       = {1'b0, acc_r[idx_r]} + {{(`DOC_ACC_W - 15){1'b0}}, regs_q.freq};
        wrap_mask_w = (ACC_ONE << high_bit_w) - ACC_ONE;
        overflow_w  = sum_w[high_bit_w];
        mode_w      = osc_mode_e'(regs_q.ctl[1]);
    end

    always_ff @(posedge clk_i) begin
        if (!reset_n_i) begin
            state_r      <= LOAD;
            idx_r        <= '0;
            wave_req_o   <= 1'b0;
            wb_o         <= '0;
            sample_o     <= '0;
            frame_done_o <= 1'b0;
            for (int i = 0; i < `DOC_NUM_OSC; i++) begin
                acc_r[i] <= '0;
            end
        end else begin
            // Single-cycle pulses
            wb_o.valid     <= 1'b0;
            sample_o.valid <= 1'b0;
            frame_done_o   <= 1'b0;

            case (state_r)
                LOAD: begin
                    state_r <= ADDR;           // Register file answers next cycle
                end
                ADDR: begin
                    regs_q <= osc_regs_i;
                    if (osc_regs_i.ctl[0]) begin
                        state_r <= NEXT;       // Halted, no fetch
                    end else begin
                        wave_addr_o <= addr_w;
                        wave_req_o  <= 1'b1;
                        state_r     <= REQ;
                    end
                end
                REQ: begin
                    if (wave_ack_i) begin
                        data_q     <= wave_data_i;
                        wave_req_o <= 1'b0;
                        state_r    <= WAIT_DROP;
                    end
                end
                WAIT_DROP: begin
                    if (!wave_ack_i) state_r <= ACC;   // Handshake complete
                end
                ACC: begin
                    wb_o.valid     <= 1'b1;
                    wb_o.idx       <= idx_r;
                    wb_o.smp_valid <= 1'b1;            // Wave sample reg tracks every fetch
                    wb_o.data      <= data_q;
                    wb_o.set_halt  <= 1'b0;
                    if (data_q == '0) begin
                        wb_o.set_halt <= 1'b1;         // End-of-table marker
                    end else begin
                        sample_o.valid <= 1'b1;
                        sample_o.wave  <= $signed(data_q ^ 8'h80);
                        sample_o.vol   <= regs_q.vol;
                        if (!overflow_w) begin
                            acc_r[idx_r] <= sum_w[`DOC_ACC_W-1:0];
                        end else if (mode_w == MODE_ONESHOT) begin
                            wb_o.set_halt <= 1'b1;
                            acc_r[idx_r]  <= '0;       // Restart from table start
                        end else begin
                            acc_r[idx_r] <= `DOC_ACC_W'(sum_w & wrap_mask_w);
                        end
                    end
                    state_r <= NEXT;
                end
                NEXT: begin
                    if (idx_r >= osc_max_i) begin
                        idx_r        <= '0;
                        frame_done_o <= 1'b1;          // Last sample already out
                    end else begin
                        idx_r <= idx_r + 1'b1;
                    end
                    state_r <= LOAD;
                end
                default: state_r <= LOAD;
            endcase
        end
    end

endmodule

// ==== rtl/doc_pkg.sv ====
//------------------------------------------------
// DOC shared types
// Engine states, modes and the bundles passed
// between register file, engine and mixer
//------------------------------------------------
`include "doc_config.svh"

package doc_pkg;

    // Per-oscillator engine states
    typedef enum logic [2:0] {
        LOAD,           // Index presented to register file
        ADDR,           // Snapshot valid, wave address formed
        REQ,            // Request high, waiting for ack
        WAIT_DROP,      // Request low, waiting for ack to fall
        ACC,            // Zero-byte, overflow and accumulator update
        NEXT            // Step index, flag end of frame
    } osc_state_e;

    // Control bit 1
    typedef enum logic {
        MODE_FREE,
        MODE_ONESHOT
    } osc_mode_e;

    typedef struct packed {
        logic                  cs_n;   // Chip select, active low
        logic                  we_n;   // Write enable, active low
        logic [7:0]            addr;
        logic [`DOC_REG_W-1:0] data;   // Write data
    } host_bus_t;

    // Register snapshot of one oscillator
    typedef struct packed {
        logic [15:0]           freq;   // {FH, FL}
        logic [`DOC_REG_W-1:0] vol;
        logic [`DOC_REG_W-1:0] wtp;
        logic [`DOC_REG_W-1:0] ctl;    // Bit 0 halt, bit 1 one-shot
        logic [`DOC_REG_W-1:0] rts;    // Bits 5:3 table size, 2:0 resolution
    } osc_regs_t;

    typedef struct packed {
        logic                      valid;
        logic [`DOC_OSC_IDX_W-1:0] idx;
        logic                      set_halt;   // Set control bit 0
        logic                      smp_valid;  // Byte fetched, goes to wave sample reg
        logic [`DOC_REG_W-1:0]     data;
    } osc_wb_t;

    typedef struct packed {
        logic                         valid;
        logic signed [`DOC_REG_W-1:0] wave;    // Offset binary already converted
        logic [`DOC_REG_W-1:0]        vol;
    } osc_sample_t;

endpackage

// ==== rtl/doc_reg_file.sv ====
`timescale 1ns/1ns
//------------------------------------------------
// DOC register file
// Host decode for the seven per-oscillator
// regions and the enable register, one engine
// snapshot per cycle, engine write-back
//------------------------------------------------
`include "doc_config.svh"

module doc_reg_file
    import doc_pkg::*;
(
    input  logic                      clk_i,
    input  logic                      reset_n_i,
    input  host_bus_t                 host_i,
    output logic [`DOC_REG_W-1:0]     host_data_o,
    input  logic [`DOC_OSC_IDX_W-1:0] osc_idx_i,
    output osc_regs_t                 osc_regs_o,
    output logic [`DOC_OSC_IDX_W-1:0] osc_max_o,
    input  osc_wb_t                   wb_i
);

    logic [`DOC_REG_W-1:0] fl_r  [`DOC_NUM_OSC];
    logic [`DOC_REG_W-1:0] fh_r  [`DOC_NUM_OSC];
    logic [`DOC_REG_W-1:0] vol_r [`DOC_NUM_OSC];
    logic [`DOC_REG_W-1:0] wds_r [`DOC_NUM_OSC];   // Written by the engine too
    logic [`DOC_REG_W-1:0] wtp_r [`DOC_NUM_OSC];
    logic [`DOC_REG_W-1:0] ctl_r [`DOC_NUM_OSC];   // Halt set by the engine
    logic [`DOC_REG_W-1:0] rts_r [`DOC_NUM_OSC];
    logic [`DOC_REG_W-1:0] en_r;

    logic [7:0]                base_w;     // Region base of the host address
    logic [`DOC_OSC_IDX_W-1:0] slot_w;
    logic                      wr_w;
    logic                      rd_w;
    logic [`DOC_REG_W-1:0]     rd_data_w;

    assign base_w    = {host_i.addr[7:5], 5'd0};
    assign slot_w    = host_i.addr[4:0];
    assign wr_w      = !host_i.cs_n && !host_i.we_n;
    assign rd_w      = !host_i.cs_n && host_i.we_n;
    assign osc_max_o = en_r[5:1];           // Highest active oscillator

    // Host read mux, E0 and up reads zero except the enable register
    always_comb begin
        rd_data_w = '0;
        case (base_w)
            `DOC_BASE_FL:  rd_data_w = fl_r[slot_w];
            `DOC_BASE_FH:  rd_data_w = fh_r[slot_w];
            `DOC_BASE_VOL: rd_data_w = vol_r[slot_w];
            `DOC_BASE_WDS: rd_data_w = wds_r[slot_w];
            `DOC_BASE_WTP: rd_data_w = wtp_r[slot_w];
            `DOC_BASE_CTL: rd_data_w = ctl_r[slot_w];
            `DOC_BASE_RTS: rd_data_w = rts_r[slot_w];
            default: begin
                if (host_i.addr == `DOC_ADDR_OSC_EN) begin
                    rd_data_w = en_r;
                end
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!reset_n_i) begin
            for (int i = 0; i < `DOC_NUM_OSC; i++) begin
                fl_r[i]  <= '0;
                fh_r[i]  <= '0;
                vol_r[i] <= '0;
                wds_r[i] <= '0;
                wtp_r[i] <= '0;
                ctl_r[i] <= '0;          // All oscillators start running
                rts_r[i] <= '0;
            end
            en_r        <= '0;           // One oscillator enabled
            host_data_o <= '0;
            osc_regs_o  <= '0;
        end else begin
            // Engine write-back, a host write further down takes priority
            if (wb_i.valid) begin
                if (wb_i.smp_valid) begin
                    wds_r[wb_i.idx] <= wb_i.data;
                end
                if (wb_i.set_halt) begin
                    ctl_r[wb_i.idx] <= ctl_r[wb_i.idx] | 8'h01;
                end
            end

            if (wr_w) begin
                case (base_w)
                    `DOC_BASE_FL:  fl_r[slot_w]  <= host_i.data;
                    `DOC_BASE_FH:  fh_r[slot_w]  <= host_i.data;
                    `DOC_BASE_VOL: vol_r[slot_w] <= host_i.data;
                    `DOC_BASE_WDS: wds_r[slot_w] <= host_i.data;
                    `DOC_BASE_WTP: wtp_r[slot_w] <= host_i.data;
                    `DOC_BASE_CTL: ctl_r[slot_w] <= host_i.data;
                    `DOC_BASE_RTS: rts_r[slot_w] <= host_i.data;
                    default: begin
                        if (host_i.addr == `DOC_ADDR_OSC_EN) begin
                            en_r <= host_i.data;
                        end
                    end
                endcase
            end

            if (rd_w) begin
                host_data_o <= rd_data_w;    // Held until the next read
            end

            // Snapshot for the engine, valid the cycle after osc_idx_i
            osc_regs_o.freq <= {fh_r[osc_idx_i], fl_r[osc_idx_i]};
            osc_regs_o.vol  <= vol_r[osc_idx_i];
            osc_regs_o.wtp  <= wtp_r[osc_idx_i];
            osc_regs_o.ctl  <= ctl_r[osc_idx_i];
            osc_regs_o.rts  <= rts_r[osc_idx_i];
        end
    end

endmodule

// ==== rtl/doc_top.sv ====
`timescale 1ns/1ns
//------------------------------------------------
// DOC sound engine top level
// Register file, oscillator engine and mixer
//------------------------------------------------
`include "doc_config.svh"

module doc_top
    import doc_pkg::*;
(
    input  logic                            clk_i,
    input  logic                            reset_n_i,
    input  host_bus_t                       host_i,
    output logic [`DOC_REG_W-1:0]           host_data_o,
    output logic                            wave_req_o,
    output logic [`DOC_WAVE_ADDR_W-1:0]     wave_addr_o,
    input  logic                            wave_ack_i,
    input  logic [`DOC_REG_W-1:0]           wave_data_i,
    output logic signed [`DOC_SAMPLE_W-1:0] mono_o,
    output logic                            mono_valid_o
);

    logic [`DOC_OSC_IDX_W-1:0] osc_idx_w;
    logic [`DOC_OSC_IDX_W-1:0] osc_max_w;
    osc_regs_t                 osc_regs_w;
    osc_wb_t                   wb_w;
    osc_sample_t               sample_w;
    logic                      frame_done_w;

    // Host decode and register storage
    doc_reg_file u_reg_file (
        .clk_i       (clk_i),
        .reset_n_i   (reset_n_i),
        .host_i      (host_i),
        .host_data_o (host_data_o),
        .osc_idx_i   (osc_idx_w),
        .osc_regs_o  (osc_regs_w),
        .osc_max_o   (osc_max_w),
        .wb_i        (wb_w)
    );

    doc_osc_engine u_osc_engine (
        .clk_i        (clk_i),
        .reset_n_i    (reset_n_i),
        .osc_idx_o    (osc_idx_w),
        .osc_regs_i   (osc_regs_w),
        .osc_max_i    (osc_max_w),
        .wb_o         (wb_w),
        .wave_req_o   (wave_req_o),
        .wave_addr_o  (wave_addr_o),
        .wave_ack_i   (wave_ack_i),
        .wave_data_i  (wave_data_i),
        .sample_o     (sample_w),
        .frame_done_o (frame_done_w)
    );

    doc_mixer u_mixer (
        .clk_i        (clk_i),
        .reset_n_i    (reset_n_i),
        .sample_i     (sample_w),
        .frame_done_i (frame_done_w),
        .mono_o       (mono_o),
        .mono_valid_o (mono_valid_o)
    );

endmodule

// ==== sources.f ====
+incdir+rtl
+incdir+test
rtl/doc_pkg.sv
rtl/doc_reg_file.sv
rtl/doc_osc_engine.sv
rtl/doc_mixer.sv
rtl/doc_top.sv
test/tb_doc.sv

// ==== test/tb_doc_model.svh ====
//------------------------------------------------
// DOC reference model
// Wave address, accumulator step, wave memory
// contents and mix arithmetic
//------------------------------------------------
`ifndef TB_DOC_MODEL_SVH
`define TB_DOC_MODEL_SVH

// Pointer page in the high byte, accumulator bits below
function automatic logic [15:0] model_addr(input logic [23:0] acc, input logic [7:0] wtp,
                                           input logic [7:0] rts);
    int         shift;
    logic [7:0] page;
    shift = 9 + int'(rts[2:0]) - int'(rts[5:3]);
    page  = wtp & (8'hFF << rts[5:3]);   // Bigger tables drop low pointer bits
    return 16'(acc >> shift) | {page, 8'h00};
endfunction

// Returns {halt, next accumulator}
function automatic logic [24:0] model_step(input logic [23:0] acc, input logic [15:0] freq,
                                           input logic [7:0] ctl, input logic [7:0] rts,
                                           input logic [7:0] wave);
    logic [24:0] sum;
    int          top;
    if (wave == 8'h00) return {1'b1, acc};          // End-of-table byte
    sum = {1'b0, acc} + 25'(freq);
    top = 17 + int'(rts[2:0]);
    if (!sum[top]) return {1'b0, sum[23:0]};
    if (ctl[1]) return {1'b1, 24'd0};               // One-shot stops at overflow
    return {1'b0, 24'(sum & ((25'd1 << top) - 25'd1))};
endfunction

// Wave memory contents, a function of the whole address
function automatic logic [7:0] wave_byte(input logic [15:0] addr, input logic [7:0] zero_page);
    logic [7:0] b;
    if (addr[15:8] == zero_page) return 8'h00;
    if (addr[15:8] == 8'hF0) return 8'hFF;          // Full positive page
    if (addr[15:8] == 8'hF1) return 8'h01;          // Full negative page
    b = addr[7:0] ^ 8'(addr[15:8] * 8'd29) ^ 8'h6B;
    if (b == 8'h00) b = 8'h80;                      // Keep it audible-silent, never zero
    return b;
endfunction

// Offset binary byte times volume
function automatic int mix_term(input logic [7:0] wave, input logic [7:0] vol);
    return int'($signed(wave ^ 8'h80)) * int'(vol);
endfunction

function automatic int clamp16(input int sum);
    if (sum > 32767) return 32767;
    if (sum < -32768) return -32768;
    return sum;
endfunction

`endif

// ==== test/tb_doc.sv ====
`timescale 1ns/1ns
//------------------------------------------------
// DOC sound engine testbench
// Host register tests, voice frames against the
// reference model, saturation, zero-byte halt,
// one-shot restart under random ack delays
//------------------------------------------------
`include "doc_config.svh"

module tb_doc
    import doc_pkg::*;
();

`include "tb_doc_model.svh"

    localparam int FRAMES    = 60 + 4 + 4;
    localparam int MAX_CYCLE = FRAMES * 32 * 16 + 20000;   // Register tests fit in the margin

    logic               clk_i = 1'b0;
    logic               reset_n_i;
    host_bus_t          host_i;
    logic [7:0]         host_data_o;
    logic               wave_req_o;
    logic [15:0]        wave_addr_o;
    logic               wave_ack_i = 1'b0;      // Owned by the memory responder
    logic [7:0]         wave_data_i = 8'h00;
    logic signed [15:0] mono_o;
    logic               mono_valid_o;

    integer     seed = 23384;
    int         cycle_count = 0;
    logic [7:0] zero_page = 8'hE0;

    // Shadow of the register file and accumulators
    logic [15:0] sh_freq [32];
    logic [7:0]  sh_vol  [32];
    logic [7:0]  sh_wtp  [32];
    logic [7:0]  sh_ctl  [32];
    logic [7:0]  sh_rts  [32];
    logic [7:0]  sh_wds  [32];
    logic [23:0] sh_acc  [32];
    int          sh_max;

    doc_top uut (
        .clk_i        (clk_i),
        .reset_n_i    (reset_n_i),
        .host_i       (host_i),
        .host_data_o  (host_data_o),
        .wave_req_o   (wave_req_o),
        .wave_addr_o  (wave_addr_o),
        .wave_ack_i   (wave_ack_i),
        .wave_data_i  (wave_data_i),
        .mono_o       (mono_o),
        .mono_valid_o (mono_valid_o)
    );

    always #4 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLE) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLE);
            $display("STATUS: FAIL");
            $fatal(1, "timeout");
        end
    end

    // Wave memory acks after 0 to 5 cycles
    always begin
        int delay;
        @(posedge clk_i);
        #1;
        if (wave_req_o) begin
            delay = $unsigned($random(seed)) % 6;
            repeat (delay) begin
                @(posedge clk_i);
                #1;
            end
            wave_data_i = wave_byte(wave_addr_o, zero_page);
            wave_ack_i  = 1'b1;
            do begin
                @(posedge clk_i);
                #1;
            end while (wave_req_o);
            wave_ack_i  = 1'b0;
            wave_data_i = 8'h00;
        end
    end

    task automatic expect_equal(input string what, input int got, input int exp);
        assert (got == exp) else begin
            $display("ERROR at %0t ns: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
            $display("STATUS: FAIL");
            $fatal(1, "check failed");
        end
    endtask

    // Host cycles start and end 1 ns after an edge
    task automatic host_write(input logic [7:0] addr, input logic [7:0] data);
        host_i = '{cs_n: 1'b0, we_n: 1'b0, addr: addr, data: data};
        @(posedge clk_i);
        #1;
        host_i.cs_n = 1'b1;
        host_i.we_n = 1'b1;
    endtask

    task automatic host_read(input logic [7:0] addr, output logic [7:0] data);
        host_i = '{cs_n: 1'b0, we_n: 1'b1, addr: addr, data: 8'h00};
        @(posedge clk_i);
        #1;
        host_i.cs_n = 1'b1;
        data = host_data_o;
    endtask

    task automatic apply_reset();
        reset_n_i = 1'b0;
        repeat (2) @(posedge clk_i);
        #1;
        reset_n_i = 1'b1;
        for (int k = 0; k < 32; k++) begin
            sh_freq[k] = '0;
            sh_vol[k]  = '0;
            sh_wtp[k]  = '0;
            sh_ctl[k]  = '0;
            sh_rts[k]  = '0;
            sh_wds[k]  = '0;
            sh_acc[k]  = '0;
        end
        sh_max = 0;
    endtask

    task automatic config_osc(input int k, input logic [15:0] freq, input logic [7:0] vol,
                              input logic [7:0] wtp, input logic [7:0] ctl,
                              input logic [7:0] rts);
        host_write(`DOC_BASE_FL + 8'(k), freq[7:0]);
        host_write(`DOC_BASE_FH + 8'(k), freq[15:8]);
        host_write(`DOC_BASE_VOL + 8'(k), vol);
        host_write(`DOC_BASE_WTP + 8'(k), wtp);
        host_write(`DOC_BASE_RTS + 8'(k), rts);
        host_write(`DOC_BASE_CTL + 8'(k), ctl);
        sh_freq[k] = freq;
        sh_vol[k]  = vol;
        sh_wtp[k]  = wtp;
        sh_rts[k]  = rts;
        sh_ctl[k]  = ctl;
    endtask

    // Oscillator 0 stays halted
    // The enable write lands in its ADDR cycle so the next NEXT steps on to oscillator 1
    task automatic start_engine(input int max);
        do begin
            @(posedge clk_i);
            #1;
        end while (!mono_valid_o);
        host_write(`DOC_ADDR_OSC_EN, 8'(max << 1));
        sh_max = max;
    endtask

    // Runs one model frame and returns in the mono_valid_o cycle
    task automatic run_frame();
        int          sum;
        logic [15:0] exp_addr;
        logic [7:0]  b;
        logic [24:0] step;
        sum = 0;
        for (int k = 0; k <= sh_max; k++) begin
            if (!sh_ctl[k][0]) begin
                do begin
                    @(posedge clk_i);
                    #1;
                    expect_equal("frame end before request", int'(mono_valid_o), 0);
                end while (!wave_req_o);
                exp_addr = model_addr(sh_acc[k], sh_wtp[k], sh_rts[k]);
                expect_equal($sformatf("wave address of osc %0d", k), wave_addr_o, exp_addr);
                while (wave_req_o) begin
                    expect_equal("address while request high", wave_addr_o, exp_addr);
                    @(posedge clk_i);
                    #1;
                end
                b         = wave_byte(exp_addr, zero_page);
                step      = model_step(sh_acc[k], sh_freq[k], sh_ctl[k], sh_rts[k], b);
                sh_acc[k] = step[23:0];
                sh_wds[k] = b;
                if (step[24]) sh_ctl[k] = sh_ctl[k] | 8'h01;
                if (b != 8'h00) sum += mix_term(b, sh_vol[k]);
            end
        end
        do begin
            @(posedge clk_i);
            #1;
            expect_equal("request after last voice", int'(wave_req_o), 0);   // Halted voices stay quiet
        end while (!mono_valid_o);
        expect_equal("mono output", int'(mono_o), clamp16(sum));
    endtask

    task automatic register_test();
        logic [7:0] d;
        logic [7:0] pat;
        for (int k = 0; k < 32; k++) host_write(`DOC_BASE_CTL + 8'(k), 8'h01);
        for (int r = 0; r < 7; r++) begin
            for (int s = 0; s < 32; s++) begin
                pat = 8'(r * 53 + s * 11 + 92);
                if (r == 5) pat = pat | 8'h01;   // Keep every oscillator halted
                host_write(8'(r * 32 + s), pat);
            end
        end
        for (int r = 0; r < 7; r++) begin
            for (int s = 0; s < 32; s++) begin
                pat = 8'(r * 53 + s * 11 + 92);
                if (r == 5) pat = pat | 8'h01;
                host_read(8'(r * 32 + s), d);
                expect_equal($sformatf("register 0x%0h", r * 32 + s), d, pat);
            end
        end
        host_write(`DOC_ADDR_OSC_EN, 8'h3E);
        host_read(`DOC_ADDR_OSC_EN, d);
        expect_equal("enable register", d, 8'h3E);
        host_write(8'hE0, 8'hAA);
        host_read(8'hE0, d);
        expect_equal("unmapped 0xE0", d, 0);
        host_read(8'hE2, d);
        expect_equal("unmapped 0xE2", d, 0);
        host_read(8'hFF, d);
        expect_equal("unmapped 0xFF", d, 0);
    endtask

    task automatic saturation_test(input logic [7:0] page);
        apply_reset();
        host_write(`DOC_BASE_CTL, 8'h01);
        sh_ctl[0] = 8'h01;
        for (int k = 1; k <= 4; k++) config_osc(k, 16'h0100, 8'hFF, page, 8'h00, 8'h00);
        start_engine(4);
        repeat (4) run_frame();
    endtask

    initial begin
        logic [7:0] d;
        reset_n_i   = 1'b0;
        host_i      = '{cs_n: 1'b1, we_n: 1'b1, addr: 8'h00, data: 8'h00};
        apply_reset();
        register_test();

        // Mixed voices plus a zero-byte voice and a one-shot voice
        apply_reset();
        host_write(`DOC_BASE_CTL, 8'h01);
        sh_ctl[0] = 8'h01;
        config_osc(1, 16'h4000, 8'h40, 8'h10, 8'h00, 8'h00);
        config_osc(2, 16'h1234, 8'h80, 8'h40, 8'h00, 8'h11);
        config_osc(3, 16'hFFFF, 8'hFF, 8'h21, 8'h00, 8'h02);
        config_osc(4, 16'h0777, 8'h30, 8'h80, 8'h00, 8'h3F);
        config_osc(5, 16'h0100, 8'h10, 8'h33, 8'h00, 8'h08);
        config_osc(6, 16'h0100, 8'hFF, zero_page, 8'h00, 8'h00);
        config_osc(7, 16'h8000, 8'h60, 8'h55, 8'h02, 8'h00);
        host_write(`DOC_BASE_WDS + 8'd6, 8'hA5);   // Replaced by the fetched zero byte
        sh_wds[6] = 8'hA5;
        start_engine(7);
        for (int f = 0; f < 60; f++) begin
            run_frame();
            case (f)
                10: begin
                    host_read(`DOC_BASE_CTL + 8'd6, d);
                    expect_equal("control of zero-byte osc", d, sh_ctl[6]);
                end
                11: begin
                    host_read(`DOC_BASE_WDS + 8'd6, d);
                    expect_equal("wave sample of zero-byte osc", d, sh_wds[6]);
                end
                20: begin
                    host_read(`DOC_BASE_WDS + 8'd3, d);
                    expect_equal("wave sample of osc 3", d, sh_wds[3]);
                end
                25: begin
                    host_read(`DOC_BASE_CTL + 8'd7, d);
                    expect_equal("control of one-shot osc", d, sh_ctl[7]);
                    expect_equal("one-shot halted", int'(d[0]), 1);
                end
                30: begin
                    host_write(`DOC_BASE_CTL + 8'd7, 8'h02);   // Restart the one-shot
                    sh_ctl[7] = 8'h02;
                end
                default: ;
            endcase
        end

        saturation_test(8'hF0);
        saturation_test(8'hF1);

        $display("STATUS: PASS");
        $finish;
    end

endmodule
